// File: list.f
+incdir+.
mem_addr_pkg.sv
map_pkg.sv
map_init.sv
map_table.sv
bank_array.sv
cache_array.sv
write_scheduler.sv
read_path.sv
core_1r1w.sv
tb_core_1r1w.sv

// File: Bender.yml
package:
  name: core_1r1w

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - mem_addr_pkg.sv
      - map_pkg.sv
      - map_init.sv
      - map_table.sv
      - bank_array.sv
      - cache_array.sv
      - write_scheduler.sv
      - read_path.sv
      - core_1r1w.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_core_1r1w.sv

// File: tb_core_1r1w.sv
`timescale 1ns/1ns
`include "core_params.svh"

module tb_core_1r1w;

  localparam int CLK_PERIOD      = 10;
  localparam int RST_CYCLES      = 5;
  localparam int NUM_ADDR        = 1 << `CORE_BITADDR;
  localparam int CONFLICT_CYCLES = 200;
  localparam int CONFLICT_RUN    = 8;
  localparam int RANDOM_CYCLES   = 2000;
  // cycles spent by all tests together, with some slack per test
  localparam int TEST_CYCLES = 40 + CONFLICT_CYCLES + NUM_ADDR + RANDOM_CYCLES + 20;

  logic                 clk;
  logic                 rst;
  logic                 vwrite;
  mem_addr_pkg::vaddr_t vwraddr;
  mem_addr_pkg::word_t  vdin;
  logic                 vread;
  mem_addr_pkg::vaddr_t vrdaddr;
  logic                 vread_vld;
  mem_addr_pkg::word_t  vdout;
  logic                 vread_fwrd;
  logic                 ready;

  // reference model
  mem_addr_pkg::word_t  model [NUM_ADDR];
  bit                   written [NUM_ADDR];
  logic                 exp_vld;
  logic                 exp_fwrd;
  logic                 exp_known;
  logic                 exp_ready;
  mem_addr_pkg::word_t  exp_data;
  logic                 prev_wr_vld;
  mem_addr_pkg::vaddr_t prev_wr_addr;

  int                   post_rst;
  int                   checks;
  int                   errors;
  int                   chk_mark;
  int                   err_mark;
  logic [31:0]          rng;

  core_1r1w u_core_1r1w (
    .clk        (clk),
    .rst        (rst),
    .vwrite     (vwrite),
    .vwraddr    (vwraddr),
    .vdin       (vdin),
    .vread      (vread),
    .vrdaddr    (vrdaddr),
    .vread_vld  (vread_vld),
    .vdout      (vdout),
    .vread_fwrd (vread_fwrd),
    .ready      (ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  // inputs change 1 ns after the rising edge
  task automatic drive(input logic wr, input mem_addr_pkg::vaddr_t wa,
                       input mem_addr_pkg::word_t wd, input logic rd,
                       input mem_addr_pkg::vaddr_t ra);
    @(posedge clk);
    #1;
    vwrite  = wr;
    vwraddr = wa;
    vdin    = wd;
    vread   = rd;
    vrdaddr = ra;
  endtask

  task automatic idle(input int n);
    repeat (n) drive(1'b0, '0, '0, 1'b0, '0);
  endtask

  task automatic finish_test(input string name);
    $display("test %-14s checks %0d errors %0d", name, checks - chk_mark, errors - err_mark);
    chk_mark = checks;
    err_mark = errors;
  endtask

  // cycles since reset was released
  always @(posedge clk) begin
    if (rst) begin
      post_rst <= 0;
    end else if (post_rst < 1000) begin
      post_rst <= post_rst + 1;
    end
  end

  // outputs and inputs are both settled mid-cycle
  always @(negedge clk) begin
    exp_ready = !rst && (post_rst >= `CORE_NUMVROW);
    checks = checks + 3;
    assert (ready === exp_ready) else begin
      $display("error: t=%0t ready expected %0b got %0b", $time, exp_ready, ready);
      errors++;
    end
    assert (vread_vld === exp_vld) else begin
      $display("error: t=%0t vread_vld expected %0b got %0b", $time, exp_vld, vread_vld);
      errors++;
    end
    assert (vread_fwrd === exp_fwrd) else begin
      $display("error: t=%0t vread_fwrd expected %0b got %0b", $time, exp_fwrd, vread_fwrd);
      errors++;
    end
    if (exp_vld && exp_known) begin
      checks++;
      assert (vdout === exp_data) else begin
        $display("error: t=%0t vdout expected %h got %h", $time, exp_data, vdout);
        errors++;
      end
    end
    // read sees the model before this cycle's write
    exp_vld   = vread && exp_ready;
    exp_known = exp_vld && written[vrdaddr];
    exp_data  = model[vrdaddr];
    exp_fwrd  = exp_vld && prev_wr_vld && (prev_wr_addr == vrdaddr);
    prev_wr_vld  = vwrite && exp_ready;
    prev_wr_addr = vwraddr;
    if (prev_wr_vld) begin
      model[vwraddr]   = vdin;
      written[vwraddr] = 1'b1;
    end
  end

  initial begin
    #(CLK_PERIOD * 2 * (RST_CYCLES + `CORE_NUMVROW + TEST_CYCLES));
    $display("watchdog timeout, the tests did not finish in time");
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    int                   wait_cnt;
    logic [31:0]          r;
    logic [31:0]          d;
    mem_addr_pkg::vbank_t bank;
    mem_addr_pkg::vrow_t  wrow;
    mem_addr_pkg::vrow_t  delta;
    mem_addr_pkg::vaddr_t a;

    // strobes stay high while the map is cleared
    rst = 1'b1;
    vwrite = 1'b1;
    vwraddr = 6'h21;
    vdin = 16'hdead;
    vread = 1'b1;
    vrdaddr = 6'h21;
    exp_vld = 1'b0;
    exp_fwrd = 1'b0;
    exp_known = 1'b0;
    exp_data = '0;
    prev_wr_vld = 1'b0;
    prev_wr_addr = '0;
    checks = 0;
    errors = 0;
    chk_mark = 0;
    err_mark = 0;
    rng = 32'h1982;
    for (int i = 0; i < NUM_ADDR; i++) begin
      written[i] = 1'b0;
      model[i] = '0;
    end

    // reset, then the map sweep
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    for (wait_cnt = 0; !ready && wait_cnt < 4 * `CORE_NUMVROW; wait_cnt++) begin
      @(posedge clk);
      #1;
    end
    if (!ready) begin
      $display("ready did not rise after the map sweep");
      errors++;
    end
    idle(4);
    finish_test("reset_ready");

    // isolated and back to back reads
    drive(1'b0, '0, '0, 1'b1, 6'h05);
    idle(1);
    drive(1'b0, '0, '0, 1'b1, 6'h13);
    drive(1'b0, '0, '0, 1'b1, 6'h27);
    drive(1'b0, '0, '0, 1'b1, 6'h3a);
    idle(3);
    finish_test("read_valid");

    // forwarding and same-cycle visibility
    drive(1'b1, 6'h2d, 16'h1111, 1'b0, '0);
    drive(1'b0, '0, '0, 1'b1, 6'h2d);
    drive(1'b1, 6'h2d, 16'h2222, 1'b1, 6'h2d);
    drive(1'b0, '0, '0, 1'b1, 6'h2d);
    idle(2);
    finish_test("forwarding");

    // same bank for a run of cycles, so each pending write meets a read of its bank
    for (int i = 0; i < CONFLICT_CYCLES; i++) begin
      r = next_rand();
      d = next_rand();
      if (i % CONFLICT_RUN == 0) begin
        bank = mem_addr_pkg::vbank_t'(r);
      end
      wrow  = mem_addr_pkg::vrow_t'(r >> 8);
      delta = mem_addr_pkg::vrow_t'(r >> 16);
      if (delta == '0) begin
        delta = 1;
      end
      drive(1'b1, {bank, wrow}, mem_addr_pkg::word_t'(d), 1'b1, {bank, wrow ^ delta});
    end
    for (int i = 0; i < NUM_ADDR; i++) begin
      a = mem_addr_pkg::vaddr_t'(i);
      drive(1'b0, '0, '0, 1'b1, a);
    end
    idle(2);
    finish_test("bank_conflict");

    // random traffic on both ports
    for (int i = 0; i < RANDOM_CYCLES; i++) begin
      r = next_rand();
      d = next_rand();
      drive(r[0] | r[1], mem_addr_pkg::vaddr_t'(r >> 8), mem_addr_pkg::word_t'(d),
            r[2] | r[3], mem_addr_pkg::vaddr_t'(r >> 16));
    end
    idle(2);
    @(negedge clk);
    finish_test("random");

    $display("total checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: core_1r1w.sv
`timescale 1ns/1ns
`include "core_params.svh"

module core_1r1w (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 vwrite,
  input  mem_addr_pkg::vaddr_t vwraddr,
  input  mem_addr_pkg::word_t  vdin,
  input  logic                 vread,
  input  mem_addr_pkg::vaddr_t vrdaddr,
  output logic                 vread_vld,
  output mem_addr_pkg::word_t  vdout,
  output logic                 vread_fwrd,
  output logic                 ready
);

  logic                 wr_vld;
  logic                 rd_vld;
  mem_addr_pkg::vrow_t  wr_row;
  mem_addr_pkg::vbank_t rd_bank;
  mem_addr_pkg::vrow_t  rd_row;

  logic                 init_we;
  mem_addr_pkg::vrow_t  init_row;
  logic                 upd_we;
  mem_addr_pkg::vrow_t  upd_row;
  map_pkg::map_entry_t  upd_entry;
  map_pkg::map_entry_t  wr_entry;
  map_pkg::map_entry_t  rd_entry;

  logic                 cache_we;
  mem_addr_pkg::vrow_t  cache_wrow;
  mem_addr_pkg::word_t  cache_wdata;
  mem_addr_pkg::vrow_t  cache_rrow1;
  mem_addr_pkg::word_t  cache_rdata1;
  mem_addr_pkg::vrow_t  cache_rrow2;
  mem_addr_pkg::word_t  cache_rdata2;

  logic                 bank_re;
  mem_addr_pkg::vbank_t bank_rbank;
  mem_addr_pkg::vrow_t  bank_rrow;
  mem_addr_pkg::word_t  bank_rdata;
  logic                 bank_we;
  mem_addr_pkg::vbank_t bank_wbank;
  mem_addr_pkg::vrow_t  bank_wrow;
  mem_addr_pkg::word_t  bank_wdata;

  logic                 pend_vld;
  mem_addr_pkg::vaddr_t pend_addr;
  mem_addr_pkg::word_t  pend_data;

  // nothing is accepted until the map is clear
  assign wr_vld = vwrite && ready;
  assign rd_vld = vread && ready;

  assign wr_row  = vwraddr[`CORE_BITVROW-1:0];
  assign rd_bank = vrdaddr[`CORE_BITADDR-1 -: `CORE_BITVBNK];
  assign rd_row  = vrdaddr[`CORE_BITVROW-1:0];

  map_init u_map_init (
    .clk      (clk),
    .rst      (rst),
    .init_we  (init_we),
    .init_row (init_row),
    .ready    (ready)
  );

  map_table u_map_table (
    .clk       (clk),
    .init_we   (init_we),
    .init_row  (init_row),
    .upd_we    (upd_we),
    .upd_row   (upd_row),
    .upd_entry (upd_entry),
    .wr_row    (wr_row),
    .wr_entry  (wr_entry),
    .rd_row    (rd_row),
    .rd_entry  (rd_entry)
  );

  bank_array u_bank_array (
    .clk        (clk),
    .bank_re    (bank_re),
    .bank_rbank (bank_rbank),
    .bank_rrow  (bank_rrow),
    .bank_rdata (bank_rdata),
    .bank_we    (bank_we),
    .bank_wbank (bank_wbank),
    .bank_wrow  (bank_wrow),
    .bank_wdata (bank_wdata)
  );

  cache_array u_cache_array (
    .clk          (clk),
    .cache_we     (cache_we),
    .cache_wrow   (cache_wrow),
    .cache_wdata  (cache_wdata),
    .cache_rrow1  (cache_rrow1),
    .cache_rdata1 (cache_rdata1),
    .cache_rrow2  (cache_rrow2),
    .cache_rdata2 (cache_rdata2)
  );

  write_scheduler u_write_scheduler (
    .clk          (clk),
    .rst          (rst),
    .wr_vld       (wr_vld),
    .wr_addr      (vwraddr),
    .wr_data      (vdin),
    .wr_entry     (wr_entry),
    .cache_rdata1 (cache_rdata1),
    .rd_vld       (rd_vld),
    .rd_bank      (rd_bank),
    .cache_rrow1  (cache_rrow1),
    .upd_we       (upd_we),
    .upd_row      (upd_row),
    .upd_entry    (upd_entry),
    .cache_we     (cache_we),
    .cache_wrow   (cache_wrow),
    .cache_wdata  (cache_wdata),
    .bank_we      (bank_we),
    .bank_wbank   (bank_wbank),
    .bank_wrow    (bank_wrow),
    .bank_wdata   (bank_wdata),
    .pend_vld     (pend_vld),
    .pend_addr    (pend_addr),
    .pend_data    (pend_data)
  );

  read_path u_read_path (
    .clk          (clk),
    .rst          (rst),
    .rd_vld       (rd_vld),
    .rd_addr      (vrdaddr),
    .rd_entry     (rd_entry),
    .pend_vld     (pend_vld),
    .pend_addr    (pend_addr),
    .pend_data    (pend_data),
    .bank_re      (bank_re),
    .bank_rbank   (bank_rbank),
    .bank_rrow    (bank_rrow),
    .cache_rrow2  (cache_rrow2),
    .cache_rdata2 (cache_rdata2),
    .bank_rdata   (bank_rdata),
    .vread_vld    (vread_vld),
    .vdout        (vdout),
    .vread_fwrd   (vread_fwrd)
  );

endmodule

// File: read_path.sv
`timescale 1ns/1ns
`include "core_params.svh"

module read_path (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 rd_vld,
  input  mem_addr_pkg::vaddr_t rd_addr,
  input  map_pkg::map_entry_t  rd_entry,
  input  logic                 pend_vld,
  input  mem_addr_pkg::vaddr_t pend_addr,
  input  mem_addr_pkg::word_t  pend_data,
  output logic                 bank_re,
  output mem_addr_pkg::vbank_t bank_rbank,
  output mem_addr_pkg::vrow_t  bank_rrow,
  output mem_addr_pkg::vrow_t  cache_rrow2,
  input  mem_addr_pkg::word_t  cache_rdata2,
  input  mem_addr_pkg::word_t  bank_rdata,
  output logic                 vread_vld,
  output mem_addr_pkg::word_t  vdout,
  output logic                 vread_fwrd
);

  mem_addr_pkg::vbank_t rd_bank;
  mem_addr_pkg::vrow_t  rd_row;
  logic                 in_cache;
  logic                 hit_cache;
  logic                 hit_pend;
  mem_addr_pkg::word_t  fwd_data;

  assign rd_bank = rd_addr[`CORE_BITADDR-1 -: `CORE_BITVBNK];
  assign rd_row  = rd_addr[`CORE_BITVROW-1:0];

  // bank and cache row are read side by side
  assign bank_re     = rd_vld;
  assign bank_rbank  = rd_bank;
  assign bank_rrow   = rd_row;
  assign cache_rrow2 = rd_row;

  assign in_cache = rd_entry[`CORE_BITVBNK] && (rd_entry[`CORE_BITVBNK-1:0] == rd_bank);
  assign hit_pend = rd_vld && pend_vld && (pend_addr == rd_addr);

  always_ff @(posedge clk) begin
    if (rst) begin
      vread_vld  <= 1'b0;
      vread_fwrd <= 1'b0;
    end else begin
      vread_vld  <= rd_vld;
      vread_fwrd <= hit_pend;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_vld) begin
      hit_cache <= in_cache;
      fwd_data  <= pend_data;
    end
  end

  // pending write first, then the cached copy, then the bank
  assign vdout = vread_fwrd ? fwd_data :
                 hit_cache  ? cache_rdata2 : bank_rdata;

endmodule

// File: write_scheduler.sv
`timescale 1ns/1ns
`include "core_params.svh"

module write_scheduler (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 wr_vld,
  input  mem_addr_pkg::vaddr_t wr_addr,
  input  mem_addr_pkg::word_t  wr_data,
  input  map_pkg::map_entry_t  wr_entry,
  input  mem_addr_pkg::word_t  cache_rdata1,
  input  logic                 rd_vld,
  input  mem_addr_pkg::vbank_t rd_bank,
  output mem_addr_pkg::vrow_t  cache_rrow1,
  output logic                 upd_we,
  output mem_addr_pkg::vrow_t  upd_row,
  output map_pkg::map_entry_t  upd_entry,
  output logic                 cache_we,
  output mem_addr_pkg::vrow_t  cache_wrow,
  output mem_addr_pkg::word_t  cache_wdata,
  output logic                 bank_we,
  output mem_addr_pkg::vbank_t bank_wbank,
  output mem_addr_pkg::vrow_t  bank_wrow,
  output mem_addr_pkg::word_t  bank_wdata,
  output logic                 pend_vld,
  output mem_addr_pkg::vaddr_t pend_addr,
  output mem_addr_pkg::word_t  pend_data
);

  mem_addr_pkg::vrow_t  wr_row;
  logic                 wr_hit_upd;
  map_pkg::map_entry_t  old_entry;
  logic                 byp_vld;
  mem_addr_pkg::word_t  byp_data;
  mem_addr_pkg::vbank_t new_bank;
  mem_addr_pkg::vrow_t  new_row;
  logic                 old_vld;
  mem_addr_pkg::vbank_t old_bank;
  mem_addr_pkg::word_t  old_data;
  logic                 new_to_cache;
  logic                 new_to_bank;
  logic                 old_to_bank;
  logic                 old_clear;

  assign wr_row      = wr_addr[`CORE_BITVROW-1:0];
  assign cache_rrow1 = wr_row;

  // table and cache still hold pre-update contents for this row
  assign wr_hit_upd = upd_we && (upd_row == wr_row);

  always_ff @(posedge clk) begin
    if (rst) begin
      pend_vld <= 1'b0;
    end else begin
      pend_vld <= wr_vld;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_vld) begin
      pend_addr <= wr_addr;
      pend_data <= wr_data;
      byp_vld   <= wr_hit_upd;
      byp_data  <= cache_wdata;
      old_entry <= wr_hit_upd ? upd_entry : wr_entry;
    end
  end

  assign new_bank = pend_addr[`CORE_BITADDR-1 -: `CORE_BITVBNK];
  assign new_row  = pend_addr[`CORE_BITVROW-1:0];
  assign old_vld  = pend_vld && old_entry[`CORE_BITVBNK];
  assign old_bank = old_entry[`CORE_BITVBNK-1:0];
  assign old_data = byp_vld ? byp_data : cache_rdata1;

  // the read owns its bank this cycle, so the new word moves aside
  assign new_to_cache = pend_vld && rd_vld && (rd_bank == new_bank);
  assign new_to_bank  = pend_vld && !new_to_cache;
  assign old_to_bank  = old_vld && new_to_cache && (old_bank != new_bank);
  assign old_clear    = old_vld && new_to_bank && (old_bank == new_bank);

  assign upd_we    = new_to_cache || old_clear;
  assign upd_row   = new_row;
  assign upd_entry = new_to_cache ? {1'b1, new_bank} : '0;

  assign cache_we    = new_to_cache;
  assign cache_wrow  = new_row;
  assign cache_wdata = pend_data;

  assign bank_we    = new_to_bank || old_to_bank;
  assign bank_wbank = new_to_bank ? new_bank : old_bank;
  assign bank_wrow  = new_row;
  assign bank_wdata = new_to_bank ? pend_data : old_data;

endmodule

// File: cache_array.sv
`timescale 1ns/1ns
`include "core_params.svh"

module cache_array (
  input  logic                clk,
  input  logic                cache_we,
  input  mem_addr_pkg::vrow_t cache_wrow,
  input  mem_addr_pkg::word_t cache_wdata,
  input  mem_addr_pkg::vrow_t cache_rrow1,
  output mem_addr_pkg::word_t cache_rdata1,
  input  mem_addr_pkg::vrow_t cache_rrow2,
  output mem_addr_pkg::word_t cache_rdata2
);

  // one spare word per row index
  mem_addr_pkg::word_t mem [`CORE_NUMVROW];

  always_ff @(posedge clk) begin
    if (cache_we) begin
      mem[cache_wrow] <= cache_wdata;
    end
  end

  // port 1 follows the incoming write row
  always_ff @(posedge clk) begin
    cache_rdata1 <= mem[cache_rrow1];
  end

  // port 2 follows the incoming read row
  always_ff @(posedge clk) begin
    cache_rdata2 <= mem[cache_rrow2];
  end

endmodule

// File: bank_array.sv
`timescale 1ns/1ns
`include "core_params.svh"

module bank_array (
  input  logic                 clk,
  input  logic                 bank_re,
  input  mem_addr_pkg::vbank_t bank_rbank,
  input  mem_addr_pkg::vrow_t  bank_rrow,
  output mem_addr_pkg::word_t  bank_rdata,
  input  logic                 bank_we,
  input  mem_addr_pkg::vbank_t bank_wbank,
  input  mem_addr_pkg::vrow_t  bank_wrow,
  input  mem_addr_pkg::word_t  bank_wdata
);

  mem_addr_pkg::word_t  bank_q [`CORE_NUMVBNK];
  mem_addr_pkg::vbank_t rsel_q;

  for (genvar b = 0; b < `CORE_NUMVBNK; b++) begin : g_bank
    mem_addr_pkg::word_t mem [`CORE_NUMVROW];
    mem_addr_pkg::word_t rd_q;

    // one access per bank per cycle
    always_ff @(posedge clk) begin
      if (bank_we && (bank_wbank == b)) begin
        mem[bank_wrow] <= bank_wdata;
      end else if (bank_re && (bank_rbank == b)) begin
        rd_q <= mem[bank_rrow];
      end
    end

    assign bank_q[b] = rd_q;
  end

  // remember which bank answers next cycle
  always_ff @(posedge clk) begin
    if (bank_re) begin
      rsel_q <= bank_rbank;
    end
  end

  assign bank_rdata = bank_q[rsel_q];

endmodule

// File: map_table.sv
`timescale 1ns/1ns
`include "core_params.svh"

module map_table (
  input  logic                clk,
  input  logic                init_we,
  input  mem_addr_pkg::vrow_t init_row,
  input  logic                upd_we,
  input  mem_addr_pkg::vrow_t upd_row,
  input  map_pkg::map_entry_t upd_entry,
  input  mem_addr_pkg::vrow_t wr_row,
  output map_pkg::map_entry_t wr_entry,
  input  mem_addr_pkg::vrow_t rd_row,
  output map_pkg::map_entry_t rd_entry
);

  map_pkg::map_entry_t entry [`CORE_NUMVROW];

  logic                grant_init;
  logic                map_we;
  mem_addr_pkg::vrow_t map_row;
  map_pkg::map_entry_t map_din;

  // sweep has priority over the scheduler
  assign grant_init = init_we;

  always_comb begin
    if (grant_init) begin
      map_we  = 1'b1;
      map_row = init_row;
      map_din = '0;
    end else begin
      map_we  = upd_we;
      map_row = upd_row;
      map_din = upd_entry;
    end
  end

  always_ff @(posedge clk) begin
    if (map_we) begin
      entry[map_row] <= map_din;
    end
  end

  // write row lookup for the scheduler
  assign wr_entry = entry[wr_row];

  // read row lookup for the read path
  assign rd_entry = entry[rd_row];

endmodule

// File: map_init.sv
`timescale 1ns/1ns
`include "core_params.svh"

module map_init (
  input  logic                clk,
  input  logic                rst,
  output logic                init_we,
  output mem_addr_pkg::vrow_t init_row,
  output logic                ready
);

  map_pkg::init_state_e state;
  mem_addr_pkg::vrow_t  row;

  // one row per cycle, then idle until the next reset
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= map_pkg::sweep;
      row   <= '0;
    end else begin
      case (state)
        map_pkg::sweep: begin
          row <= row + 1'b1;
          if (row == mem_addr_pkg::vrow_t'(`CORE_NUMVROW - 1)) begin
            state <= map_pkg::done;
          end
        end
        default: state <= map_pkg::done;
      endcase
    end
  end

  assign init_we  = (state == map_pkg::sweep);
  assign init_row = row;
  assign ready    = (state == map_pkg::done);

endmodule

// File: map_pkg.sv
package map_pkg;

  // valid flag above the bank that owns the cached row
  typedef logic [$bits(mem_addr_pkg::vbank_t):0] map_entry_t;

  // map clearing after reset
  typedef enum logic {
    sweep,
    done
  } init_state_e;

endpackage

// File: mem_addr_pkg.sv
`include "core_params.svh"

package mem_addr_pkg;

  // virtual address with the bank above the row
  typedef logic [`CORE_BITADDR-1:0] vaddr_t;

  // bank index
  typedef logic [`CORE_BITVBNK-1:0] vbank_t;

  // row index inside a bank
  typedef logic [`CORE_BITVROW-1:0] vrow_t;

  // one data word
  typedef logic [`CORE_WIDTH-1:0] word_t;

endpackage

// File: core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// data word width
`define CORE_WIDTH 16

// banks and bank index bits
`define CORE_NUMVBNK 4
`define CORE_BITVBNK 2

// rows per bank and row index bits
`define CORE_NUMVROW 16
`define CORE_BITVROW 4

// bank index above row index
`define CORE_BITADDR (`CORE_BITVBNK + `CORE_BITVROW)

`endif
